/* build.f */
+incdir+include
logic/fifo_pkg.sv
logic/fifo_ctrl.sv
logic/ram_2p_asym.sv
logic/word_sender.sv
logic/credit_return.sv
logic/byte_word_buffer.sv
tests/tb_byte_word_buffer.sv

/* run_sim.sh */
#!/bin/sh
# build and run the byte to word buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_byte_word_buffer
OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   -f build.f --top-module "$TOP" -Mdir "$OBJ_DIR"
status=$?
if [ "$status" -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

"./$OBJ_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q '\*\*\* FAILED \*\*\*' "$LOG"; then
   echo "testbench reported a failure, see $LOG"
   exit 1
fi

if [ "$status" -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

echo "simulation finished, log in $LOG"
exit 0

/* include/tb_tasks.svh */
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// one clock step, ending just after the edge
task automatic tick();
   @(posedge clk);
   #1;
endtask

task automatic idle(input int cycles);
   repeat (cycles) tick();
endtask

task automatic check_word(input string name, input word_t exp, input word_t act);
   if (act !== exp) begin
      $display("[ERROR] %s expected 0x%08h actual 0x%08h", name, exp, act);
      stop_run();
   end
endtask

task automatic check_level(input string name, input level_t exp, input level_t act);
   if (act !== exp) begin
      $display("[ERROR] %s expected level %0d actual level %0d", name, exp, act);
      stop_run();
   end
endtask

task automatic check_count(input string name, input cred_t exp, input cred_t act);
   if (act !== exp) begin
      $display("[ERROR] %s expected count %0d actual count %0d", name, exp, act);
      stop_run();
   end
endtask

// spends one upstream credit, waits for one if none is left
task automatic send_byte(input byte_t b);
   int waited;
   waited = 0;
   while (tb_credits == 0) begin
      if (waited == WAIT_LIMIT) begin
         $display("%s: timed out waiting for an upstream credit", cur_test);
         stop_run();
      end
      waited++;
      tick();
   end
   in_valid = 1'b1;
   in_data = b;
   ref_q.push_back(b);
   tb_credits--;
   tick();
   in_valid = 1'b0;
endtask

// one downstream credit pulse
task automatic grant_credit();
   out_credit = 1'b1;
   tick();
   out_credit = 1'b0;
endtask

task automatic wait_words(input int target);
   int waited;
   waited = 0;
   while (words_seen < target) begin
      if (waited == WAIT_LIMIT) begin
         $display("%s: timed out waiting for output word number %0d", cur_test, target);
         stop_run();
      end
      waited++;
      tick();
   end
endtask

task automatic wait_credits(input int target);
   int waited;
   waited = 0;
   while (tb_credits != target) begin
      if (waited == WAIT_LIMIT) begin
         $display("%s: timed out with %0d upstream credits, wanted %0d",
                  cur_test, tb_credits, target);
         stop_run();
      end
      waited++;
      tick();
   end
endtask

// DUT has nothing more to return once in_credit drops
task automatic wait_credit_idle();
   int waited;
   waited = 0;
   while (in_credit !== 1'b0) begin
      if (waited == WAIT_LIMIT) begin
         $display("%s: timed out waiting for the credit return to finish", cur_test);
         stop_run();
      end
      waited++;
      tick();
   end
endtask

`endif

/* tests/tb_byte_word_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_byte_word_buffer
   import fifo_pkg::*;
();

   localparam int WAIT_LIMIT = 2000;

   logic   clk = 1'b0;
   logic   rst;
   logic   in_valid;
   byte_t  in_data;
   logic   in_credit;
   logic   out_credit;
   logic   out_valid;
   word_t  out_data;
   level_t level;

   // reference model and bookkeeping
   byte_t ref_q [$];
   int    tb_credits;
   int    words_seen;
   int    pulses_seen;
   int    cyc = 0;
   int    valid_cyc;
   word_t last_word;
   word_t exp_word;
   string cur_test = "startup";

   always #5 clk = ~clk;

   always @(posedge clk) begin
      cyc <= cyc + 1;
   end

   byte_word_buffer u_byte_word_buffer (
      .clk        (clk),
      .rst        (rst),
      .in_valid   (in_valid),
      .in_data    (in_data),
      .in_credit  (in_credit),
      .out_credit (out_credit),
      .out_valid  (out_valid),
      .out_data   (out_data),
      .level      (level)
   );

   task automatic stop_run();
      $display("*** FAILED ***");
      $fatal(1, "stopping at the first error");
   endtask

   `include "tb_tasks.svh"

   // outputs are registered, so the falling edge sees them settled
   always @(negedge clk) begin
      if (!rst && in_credit) begin
         tb_credits++;
         pulses_seen++;
         if (tb_credits > DEPTH_BYTES) begin
            $display("%s: more upstream credits came back than bytes were sent", cur_test);
            stop_run();
         end
      end
      if (!rst && out_valid) begin
         if (ref_q.size() < LANES) begin
            $display("%s: a word came out with only %0d bytes sent",
                     cur_test, ref_q.size());
            stop_run();
         end else begin
            // oldest byte goes to bits 7:0
            for (int i = 0; i < LANES; i++) begin
               exp_word[i*BYTE_W +: BYTE_W] = ref_q.pop_front();
            end
            check_word(cur_test, exp_word, out_data);
            last_word = out_data;
            valid_cyc = cyc;
            words_seen++;
         end
      end
   end

   task automatic test_reset_state();
      cur_test = "reset_state";
      for (int i = 0; i < 10; i++) begin
         tick();
         if (out_valid !== 1'b0 || in_credit !== 1'b0) begin
            $display("%s: out_valid or in_credit high after reset", cur_test);
            stop_run();
         end
      end
      check_level(cur_test, level_t'(0), level);
   endtask

   task automatic test_packing();
      byte_t bytes [4];
      int    base_w;
      int    write_cyc;
      cur_test = "packing";
      bytes[0] = 8'ha1;
      bytes[1] = 8'hb2;
      bytes[2] = 8'hc3;
      bytes[3] = 8'hd4;
      // credit is already held when the word completes
      grant_credit();
      idle(2);
      base_w = words_seen;
      for (int i = 0; i < 4; i++) begin
         send_byte(bytes[i]);
      end
      write_cyc = cyc;
      wait_words(base_w + 1);
      check_word(cur_test, {bytes[3], bytes[2], bytes[1], bytes[0]}, last_word);
      check_count({cur_test, " latency"}, cred_t'(2), cred_t'(valid_cyc - write_cyc));
      wait_credits(DEPTH_BYTES);
      check_level(cur_test, level_t'(0), level);
   endtask

   task automatic test_backpressure();
      int base_w;
      cur_test = "backpressure";
      base_w = words_seen;
      for (int i = 0; i < 8; i++) begin
         send_byte(byte_t'($urandom));
      end
      idle(30);
      check_count({cur_test, " held words"}, cred_t'(0), cred_t'(words_seen - base_w));
      check_level(cur_test, level_t'(8), level);
      repeat (2) grant_credit();
      wait_words(base_w + 2);
      idle(10);
      check_count({cur_test, " released words"}, cred_t'(2), cred_t'(words_seen - base_w));
      check_level(cur_test, level_t'(0), level);
      wait_credits(DEPTH_BYTES);
   endtask

   task automatic test_credit_return();
      int base_w;
      int base_p;
      cur_test = "credit_return";
      for (int w = 0; w < 4; w++) begin
         base_w = words_seen;
         base_p = pulses_seen;
         repeat (4) send_byte(byte_t'($urandom));
         grant_credit();
         wait_words(base_w + 1);
         wait_credit_idle();
         // no extra pulses trail behind
         idle(8);
         check_count({cur_test, " pulses"}, cred_t'(4), cred_t'(pulses_seen - base_p));
         check_count({cur_test, " pulse total"}, cred_t'(4 * words_seen),
                     cred_t'(pulses_seen));
      end
   endtask

   task automatic test_full_depth();
      int base_w;
      int base_p;
      cur_test = "full_depth";
      base_w = words_seen;
      base_p = pulses_seen;
      for (int i = 0; i < DEPTH_BYTES; i++) begin
         send_byte(byte_t'($urandom));
      end
      check_level(cur_test, level_t'(DEPTH_BYTES), level);
      check_count({cur_test, " credits left"}, cred_t'(0), cred_t'(tb_credits));
      repeat (16) grant_credit();
      wait_words(base_w + 16);
      wait_credit_idle();
      idle(4);
      check_count({cur_test, " words"}, cred_t'(16), cred_t'(words_seen - base_w));
      check_count({cur_test, " pulses"}, cred_t'(64), cred_t'(pulses_seen - base_p));
      check_level(cur_test, level_t'(0), level);
   endtask

   task automatic test_random_stream();
      int base_w;
      cur_test = "random_stream";
      base_w = words_seen;
      fork
         begin : producer
            for (int i = 0; i < 400; i++) begin
               repeat ($urandom_range(3)) tick();
               send_byte(byte_t'($urandom));
            end
         end
         begin : consumer
            for (int g = 0; g < 100; g++) begin
               repeat ($urandom_range(7)) tick();
               grant_credit();
            end
         end
      join
      wait_words(base_w + 100);
      wait_credit_idle();
      check_count({cur_test, " words"}, cred_t'(100), cred_t'(words_seen - base_w));
      check_count({cur_test, " credits"}, cred_t'(DEPTH_BYTES), cred_t'(tb_credits));
      check_level(cur_test, level_t'(0), level);
   endtask

   initial begin
      void'($urandom(37036));
      rst = 1'b1;
      in_valid = 1'b0;
      in_data = '0;
      out_credit = 1'b0;
      tb_credits = DEPTH_BYTES;
      words_seen = 0;
      pulses_seen = 0;
      repeat (8) @(posedge clk);
      #1;
      rst = 1'b0;

      test_reset_state();
      test_packing();
      test_backpressure();
      test_credit_return();
      test_full_depth();
      test_random_stream();

      $display("*** PASSED ***");
      $finish;
   end

endmodule

`default_nettype wire

/* logic/byte_word_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module byte_word_buffer
   import fifo_pkg::*;
(
   input  wire         clk,
   input  wire         rst,

   // producer side
   input  wire         in_valid,
   input  wire byte_t  in_data,
   output logic        in_credit,

   // consumer side
   input  wire         out_credit,
   output logic        out_valid,
   output word_t       out_data,

   // bytes currently stored
   output level_t      level
);

   logic   wr_en;
   baddr_t wr_addr;
   waddr_t rd_addr;
   logic   rd_empty;
   logic   rd_req;
   logic   word_freed;
   word_t  rd_data;

   fifo_ctrl u_ctrl (
      .clk        (clk),
      .rst        (rst),
      .in_valid   (in_valid),
      .wr_en      (wr_en),
      .wr_addr    (wr_addr),
      .rd_req     (rd_req),
      .rd_addr    (rd_addr),
      .rd_empty   (rd_empty),
      .word_freed (word_freed),
      .level      (level)
   );

   // accepted read doubles as the RAM read enable
   ram_2p_asym u_ram (
      .clk     (clk),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .wr_data (in_data),
      .rd_en   (word_freed),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

   word_sender u_sender (
      .clk        (clk),
      .rst        (rst),
      .out_credit (out_credit),
      .rd_empty   (rd_empty),
      .rd_data    (rd_data),
      .rd_req     (rd_req),
      .out_valid  (out_valid),
      .out_data   (out_data)
   );

   credit_return u_credit (
      .clk        (clk),
      .rst        (rst),
      .word_freed (word_freed),
      .in_credit  (in_credit)
   );

endmodule

`default_nettype wire

/* logic/credit_return.sv */
`timescale 1ns/1ps
`default_nettype none

module credit_return
   import fifo_pkg::*;
(
   input  wire  clk,
   input  wire  rst,

   // one word left the FIFO
   input  wire  word_freed,

   // one byte credit back to the producer
   output logic in_credit
);

   cred_t pending;
   cred_t pending_nxt;

   // four bytes freed per word, one returned per pulse
   always_comb begin
      pending_nxt = pending;
      if (word_freed) begin
         pending_nxt = pending_nxt + cred_t'(LANES);
      end
      if (in_credit) begin
         pending_nxt = pending_nxt - cred_t'(1);
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         pending <= '0;
         in_credit <= 1'b0;
      end else begin
         pending <= pending_nxt;
         in_credit <= pending_nxt != '0;
      end
   end

   // bytes still owed never exceed what the FIFO could hold
   a_pending_bound : assert property (
      @(posedge clk) disable iff (rst)
      pending <= cred_t'(DEPTH_BYTES)
   ) else $error("pending credits %0d above FIFO depth", pending);

endmodule

`default_nettype wire

/* logic/word_sender.sv */
`timescale 1ns/1ps
`default_nettype none

module word_sender
   import fifo_pkg::*;
(
   input  wire        clk,
   input  wire        rst,

   // downstream credits, one pulse per word
   input  wire        out_credit,

   // FIFO side
   input  wire        rd_empty,
   input  wire word_t rd_data,
   output logic       rd_req,

   // word output
   output logic       out_valid,
   output word_t      out_data
);

   cred_t credits;
   logic  rd_pend;

   // ask for a word whenever a credit and a full word are both there
   assign rd_req = (credits != '0) && !rd_empty;

   // credit in and word out in one cycle cancel
   always_ff @(posedge clk) begin
      if (rst) begin
         credits <= '0;
      end else begin
         case ({out_credit, rd_req})
            2'b10: credits <= credits + cred_t'(1);
            2'b01: credits <= credits - cred_t'(1);
            default: credits <= credits;
         endcase
      end
   end

   // read data shows up one cycle after the request
   always_ff @(posedge clk) begin
      if (rst) begin
         rd_pend <= 1'b0;
         out_valid <= 1'b0;
      end else begin
         rd_pend <= rd_req;
         out_valid <= rd_pend;
      end
   end

   always_ff @(posedge clk) begin
      if (rd_pend) begin
         out_data <= rd_data;
      end
   end

   // consumer never grants more credits than the counter can hold
   a_credit_no_wrap : assert property (
      @(posedge clk) disable iff (rst)
      (out_credit && !rd_req) |-> credits != '1
   ) else $error("downstream credit counter wrapped");

endmodule

`default_nettype wire

/* logic/ram_2p_asym.sv */
`timescale 1ns/1ps
`default_nettype none

module ram_2p_asym
   import fifo_pkg::*;
(
   input  wire         clk,

   // byte write port
   input  wire         wr_en,
   input  wire baddr_t wr_addr,
   input  wire byte_t  wr_data,

   // word read port
   input  wire         rd_en,
   input  wire waddr_t rd_addr,
   output word_t       rd_data
);

   waddr_t wr_word;
   byte_t  rd_lane [LANES];

   // upper address bits pick the word, low bits the lane
   assign wr_word = wr_addr[BADDR_W-1 -: WADDR_W];

   for (genvar l = 0; l < LANES; l++) begin : g_lane
      byte_t lane_mem [2**WADDR_W];

      always_ff @(posedge clk) begin
         if (wr_en && wr_addr[BADDR_W-WADDR_W-1:0] == l) begin
            lane_mem[wr_word] <= wr_data;
         end
      end

      // registered read, holds when not enabled
      always_ff @(posedge clk) begin
         if (rd_en) begin
            rd_lane[l] <= lane_mem[rd_addr];
         end
      end
   end

   // lane 0 is the oldest byte, so it goes in the low bits
   always_comb begin
      for (int i = 0; i < LANES; i++) begin
         rd_data[i*BYTE_W +: BYTE_W] = rd_lane[i];
      end
   end

endmodule

`default_nettype wire

/* logic/fifo_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module fifo_ctrl
   import fifo_pkg::*;
(
   input  wire    clk,
   input  wire    rst,

   // byte write side
   input  wire    in_valid,
   output logic   wr_en,
   output baddr_t wr_addr,

   // word read side
   input  wire    rd_req,
   output waddr_t rd_addr,
   output logic   rd_empty,
   output logic   word_freed,

   // occupancy in bytes
   output level_t level
);

   logic   wr_fire;
   logic   rd_fire;
   level_t level_nxt;

   // no full gating here, the upstream credits keep writes in bounds
   assign wr_fire = in_valid;

   // a word leaves only when four bytes are really there
   assign rd_fire = rd_req && !rd_empty;

   assign wr_en = wr_fire;

   // the freed word is reported in the same cycle as the read
   assign word_freed = rd_fire;

   // fewer than one full word stored
   assign rd_empty = level < level_t'(LANES);

   // write adds one byte, read removes a whole word
   always_comb begin
      level_nxt = level;
      if (wr_fire && !rd_fire) begin
         level_nxt = level + level_t'(1);
      end else if (wr_fire && rd_fire) begin
         level_nxt = level + level_t'(1) - level_t'(LANES);
      end else if (!wr_fire && rd_fire) begin
         level_nxt = level - level_t'(LANES);
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         level <= '0;
      end else begin
         level <= level_nxt;
      end
   end

   // byte pointer, wraps at the depth
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_addr <= '0;
      end else if (wr_fire) begin
         wr_addr <= wr_addr + baddr_t'(1);
      end
   end

   // word pointer, one step per word
   always_ff @(posedge clk) begin
      if (rst) begin
         rd_addr <= '0;
      end else if (rd_fire) begin
         rd_addr <= rd_addr + waddr_t'(1);
      end
   end

   // producer must have run out of credits before the FIFO is full
   a_no_write_when_full : assert property (
      @(posedge clk) disable iff (rst)
      in_valid |-> level != level_t'(DEPTH_BYTES)
   ) else $error("byte written while FIFO holds %0d bytes", level);

   // sender only asks for a word that is already complete
   a_no_read_when_empty : assert property (
      @(posedge clk) disable iff (rst)
      rd_req |-> !rd_empty
   ) else $error("word requested with level %0d", level);

endmodule

`default_nettype wire

/* logic/fifo_pkg.sv */
`default_nettype none

package fifo_pkg;

   // byte in, word out
   localparam int BYTE_W = 8;
   localparam int WORD_W = 32;
   localparam int LANES = WORD_W / BYTE_W;

   // storage depth, counted in bytes
   localparam int DEPTH_BYTES = 64;
   localparam int BADDR_W = 6;
   localparam int WADDR_W = 4;

   // level has to reach DEPTH_BYTES itself
   localparam int LEVEL_W = 7;

   typedef logic [BYTE_W-1:0] byte_t;
   typedef logic [WORD_W-1:0] word_t;
   typedef logic [BADDR_W-1:0] baddr_t;
   typedef logic [WADDR_W-1:0] waddr_t;
   typedef logic [LEVEL_W-1:0] level_t;

   // word credits downstream, pending byte credits upstream
   typedef logic [LEVEL_W-1:0] cred_t;

endpackage

`default_nettype wire
